//--- rtl/fetch_pkg.sv
package fetch_pkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 8;
  localparam int IM_WORDS  = 1 << ADDR_W;
  localparam int CNT_W     = ADDR_W + 1; // holds 0..IM_WORDS.
  localparam logic [ADDR_W-1:0] IM_START = 8'h80;

  // instruction field widths.
  localparam int OP_W  = 6;
  localparam int REG_W = 5;
  localparam int IMM_W = 16;
  localparam int TGT_W = 26;

  localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
  localparam logic [OP_W-1:0] OP_J     = 6'h02;
  localparam logic [OP_W-1:0] OP_JAL   = 6'h03;
  localparam logic [OP_W-1:0] OP_ANDI  = 6'h0c; // logical immediates.
  localparam logic [OP_W-1:0] OP_ORI   = 6'h0d;
  localparam logic [OP_W-1:0] OP_XORI  = 6'h0e;

  typedef enum logic [1:0] {
    CLS_R,
    CLS_I,
    CLS_J
  } instr_class_e;

  // raw word views, one per format.
  typedef struct packed {
    logic [OP_W-1:0]  opcode;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] shamt;
    logic [OP_W-1:0]  funct;
  } instr_r_t;

  typedef struct packed {
    logic [OP_W-1:0]  opcode;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [IMM_W-1:0] imm;
  } instr_i_t;

  typedef struct packed {
    logic [OP_W-1:0]  opcode;
    logic [TGT_W-1:0] target;
  } instr_j_t;

  typedef struct packed {
    logic              en;
    logic              rd;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } im_req_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] instr;
  } fetch_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    instr_class_e      cls;
    logic [OP_W-1:0]   opcode;
    logic [REG_W-1:0]  rs;
    logic [REG_W-1:0]  rt;
    logic [REG_W-1:0]  rd;
    logic [REG_W-1:0]  shamt;
    logic [OP_W-1:0]   funct;
    logic [DATA_W-1:0] imm;    // already extended.
    logic [TGT_W-1:0]  target;
  } decoded_t;

endpackage

//--- rtl/instr_mem.sv
`timescale 1ns/100ps

module instr_mem (
  input  logic                           clk,
  input  logic                           rst,
  input  fetch_pkg::im_req_t             req,
  output logic [fetch_pkg::DATA_W-1:0]   rdata
);

  import fetch_pkg::*;

  logic [DATA_W-1:0] mem [IM_WORDS];

  // single port, one cycle read latency.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < IM_WORDS; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (req.en) begin
      if (req.rd) begin
        rdata <= mem[req.addr]; // read wins over write.
      end else if (req.wr) begin
        mem[req.addr] <= req.wdata;
      end
    end
  end

endmodule

//--- rtl/im_loader.sv
`timescale 1ns/100ps

module im_loader (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic                          load_start,
  input  logic                          load_valid,
  input  logic [fetch_pkg::DATA_W-1:0]  load_data,
  output fetch_pkg::im_req_t            req,
  output logic [fetch_pkg::CNT_W-1:0]   load_count
);

  import fetch_pkg::*;

  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] wr_addr;
  logic              wr_en;

  assign wr_en = load_valid & ~run; // no loading while fetching.
  // a strobe together with load_start lands on the boot address.
  assign wr_addr = load_start ? IM_START : wr_ptr;

  always_comb begin
    req.en    = wr_en;
    req.rd    = 1'b0;
    req.wr    = wr_en;
    req.addr  = wr_addr;
    req.wdata = load_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= IM_START;
      load_count <= '0;
    end else begin
      if (load_start || wr_en) begin
        wr_ptr <= wr_addr + ADDR_W'(wr_en); // wraps at the top.
      end
      if (load_start) begin
        load_count <= CNT_W'(wr_en);
      end else if (wr_en && load_count != CNT_W'(IM_WORDS)) begin
        load_count <= load_count + 1'b1;
      end
    end
  end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic                          redirect,
  input  logic [fetch_pkg::ADDR_W-1:0]  redirect_pc,
  output fetch_pkg::im_req_t            req,
  input  logic [fetch_pkg::DATA_W-1:0]  rdata,
  output fetch_pkg::fetch_t             fetched
);

  import fetch_pkg::*;

  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_next;

  // tag of the read now in the memory.
  logic              tag_valid;
  logic [ADDR_W-1:0] tag_pc;

  // one read per cycle at pc while running.
  always_comb begin
    req.en    = run;
    req.rd    = run;
    req.wr    = 1'b0;
    req.addr  = pc;
    req.wdata = '0;
  end

  always_comb begin
    pc_next = pc;
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (run) begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= IM_START;
      tag_valid <= 1'b0;
    end else begin
      pc        <= pc_next;
      // read issued under a redirect is never marked.
      tag_valid <= run & ~redirect;
    end
  end

  always_ff @(posedge clk) begin
    tag_pc <= pc;
  end

  // the read issued last cycle is flushed too.
  always_comb begin
    fetched.valid = tag_valid & ~redirect;
    fetched.pc    = tag_pc;
    fetched.instr = rdata;
  end

endmodule

//--- rtl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::fetch_t   fetched,
  output fetch_pkg::decoded_t dec
);

  import fetch_pkg::*;

  instr_r_t     w_r;
  instr_i_t     w_i;
  instr_j_t     w_j;
  instr_class_e cls;
  logic         zext;
  decoded_t     dec_d;

  assign w_r = instr_r_t'(fetched.instr);
  assign w_i = instr_i_t'(fetched.instr);
  assign w_j = instr_j_t'(fetched.instr);

  always_comb begin
    case (w_r.opcode)
      OP_RTYPE:     cls = CLS_R;
      OP_J, OP_JAL: cls = CLS_J;
      default:      cls = CLS_I;
    endcase
  end

  // logical ops take an unsigned immediate.
  assign zext = (w_i.opcode == OP_ANDI) ||
                (w_i.opcode == OP_ORI)  ||
                (w_i.opcode == OP_XORI);

  always_comb begin
    dec_d.valid  = fetched.valid;
    dec_d.pc     = fetched.pc;
    dec_d.cls    = cls;
    dec_d.opcode = w_r.opcode;
    dec_d.rs     = w_r.rs;
    dec_d.rt     = w_r.rt;
    dec_d.rd     = w_r.rd;
    dec_d.shamt  = w_r.shamt;
    dec_d.funct  = w_r.funct;
    dec_d.target = w_j.target;
    if (zext) begin
      dec_d.imm = {{(DATA_W-IMM_W){1'b0}}, w_i.imm};
    end else begin
      dec_d.imm = {{(DATA_W-IMM_W){w_i.imm[IMM_W-1]}}, w_i.imm};
    end
  end

  always_ff @(posedge clk) begin
    dec <= dec_d;
    if (rst) begin
      dec.valid <= 1'b0;
    end
  end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic                          load_start,
  input  logic                          load_valid,
  input  logic [fetch_pkg::DATA_W-1:0]  load_data,
  input  logic                          redirect,
  input  logic [fetch_pkg::ADDR_W-1:0]  redirect_pc,
  output fetch_pkg::decoded_t           dec,
  output logic [fetch_pkg::CNT_W-1:0]   load_count
);

  import fetch_pkg::*;

  im_req_t           load_req;
  im_req_t           fetch_req;
  im_req_t           mem_req;
  logic [DATA_W-1:0] rdata;
  fetch_t            fetched;

  im_loader u_loader (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .load_start (load_start),
    .load_valid (load_valid),
    .load_data  (load_data),
    .req        (load_req),
    .load_count (load_count)
  );

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .req         (fetch_req),
    .rdata       (rdata),
    .fetched     (fetched)
  );

  // fetch owns the port while running, loader otherwise.
  assign mem_req = run ? fetch_req : load_req;

  instr_mem u_mem (
    .clk   (clk),
    .rst   (rst),
    .req   (mem_req),
    .rdata (rdata)
  );

  instr_decoder u_dec (
    .clk     (clk),
    .rst     (rst),
    .fetched (fetched),
    .dec     (dec)
  );

endmodule

//--- dv/fetch_props.sv
`timescale 1ns/100ps

module fetch_props (
  input logic                clk,
  input logic                rst,
  input logic                redirect,
  input fetch_pkg::im_req_t  load_req,
  input fetch_pkg::im_req_t  fetch_req,
  input fetch_pkg::decoded_t dec
);

  import fetch_pkg::*;

  logic              have_prev;
  logic              redir_seen;
  logic [ADDR_W-1:0] prev_pc;

  // last valid pc, and whether a redirect came since.
  always_ff @(posedge clk) begin
    if (rst) begin
      have_prev  <= 1'b0;
      redir_seen <= 1'b0;
      prev_pc    <= '0;
    end else if (dec.valid) begin
      have_prev  <= 1'b1;
      redir_seen <= redirect;
      prev_pc    <= dec.pc;
    end else if (redirect) begin
      redir_seen <= 1'b1;
    end
  end

  a_reset_valid: assert property (@(posedge clk) rst |=> !dec.valid)
    else $error("dec.valid high after a reset cycle");

  a_port_conflict: assert property (@(posedge clk) disable iff (rst)
    !(load_req.wr && fetch_req.rd))
    else $error("memory request carries a load write and a fetch read");

  a_pc_sequence: assert property (@(posedge clk) disable iff (rst)
    (dec.valid && have_prev && !redir_seen) |-> dec.pc == prev_pc + 1'b1)
    else $error("pc %0h does not follow %0h", dec.pc, prev_pc);

endmodule

bind fetch_top fetch_props u_props (
  .clk       (clk),
  .rst       (rst),
  .redirect  (redirect),
  .load_req  (load_req),
  .fetch_req (fetch_req),
  .dec       (dec)
);

//--- dv/fetch_top_tb.sv
`timescale 1ns/100ps

module fetch_top_tb;

  import fetch_pkg::*;

  logic              clk;
  logic              rst;
  logic              run;
  logic              load_start;
  logic              load_valid;
  logic [DATA_W-1:0] load_data;
  logic              redirect;
  logic [ADDR_W-1:0] redirect_pc;
  decoded_t          dec;
  logic [CNT_W-1:0]  load_count;

  // reference model state.
  logic [DATA_W-1:0] mem_m [IM_WORDS];
  logic [ADDR_W-1:0] ptr_m;
  logic [CNT_W-1:0]  cnt_m;
  logic [ADDR_W-1:0] pc_m;
  logic              pushed_m; // a read was issued on the last edge.
  logic [ADDR_W-1:0] exp_q [$];

  logic [31:0]       seed;
  logic [OP_W-1:0]   iops [8] = '{OP_ANDI, OP_ORI, OP_XORI, 6'h08, 6'h09, 6'h23, 6'h2b, 6'h04};
  int                errors;
  int                checks;
  int                tests;
  int                n_out;
  int                test_err0;

  fetch_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .load_start  (load_start),
    .load_valid  (load_valid),
    .load_data   (load_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .dec         (dec),
    .load_count  (load_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    seed = xorshift(seed);
    return seed;
  endfunction

  // bias toward R and J words so every class shows up.
  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = rand32();
    case (w[1:0])
      2'd0:    w[31:26] = OP_RTYPE;
      2'd1:    w[31:26] = w[2] ? OP_JAL : OP_J;
      default: ;
    endcase
    return w;
  endfunction

  function automatic decoded_t expect_dec(input logic [ADDR_W-1:0] pc);
    logic [DATA_W-1:0] w;
    decoded_t          d;
    w        = mem_m[pc];
    d.valid  = 1'b1;
    d.pc     = pc;
    d.opcode = w[31:26];
    d.rs     = w[25:21];
    d.rt     = w[20:16];
    d.rd     = w[15:11];
    d.shamt  = w[10:6];
    d.funct  = w[5:0];
    d.target = w[25:0];
    if (w[31:26] == OP_RTYPE) begin
      d.cls = CLS_R;
    end else if (w[31:26] == OP_J || w[31:26] == OP_JAL) begin
      d.cls = CLS_J;
    end else begin
      d.cls = CLS_I;
    end
    if (w[31:26] == OP_ANDI || w[31:26] == OP_ORI || w[31:26] == OP_XORI) begin
      d.imm = {16'h0000, w[15:0]};
    end else begin
      d.imm = {{16{w[15]}}, w[15:0]};
    end
    return d;
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic observe();
    logic [ADDR_W-1:0] p;
    check(load_count, cnt_m, "load_count");
    if (dec.valid === 1'b1) begin
      n_out++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected valid output with pc %0h at %0t ns", dec.pc, $time);
      end else begin
        p = exp_q.pop_front();
        check(dec, expect_dec(p), $sformatf("decoded item at pc %0h", p));
      end
    end
  endtask

  // one clock: check outputs, drive inputs, advance the model.
  task automatic step(input logic r, input logic rdr, input logic [ADDR_W-1:0] rpc,
                      input logic ls, input logic lv, input logic [DATA_W-1:0] ld);
    @(negedge clk);
    observe();
    run         = r;
    redirect    = rdr;
    redirect_pc = rpc;
    load_start  = ls;
    load_valid  = lv;
    load_data   = ld;
    if (ls) begin
      ptr_m = IM_START;
      cnt_m = '0;
    end
    if (lv && !r) begin
      mem_m[ptr_m] = ld;
      ptr_m++;
      if (cnt_m != IM_WORDS) cnt_m++;
    end
    if (rdr && pushed_m) void'(exp_q.pop_back()); // flushed before reaching dec.
    pushed_m = r && !rdr;
    if (pushed_m) exp_q.push_back(pc_m);
    if (rdr) begin
      pc_m = rpc;
    end else if (r) begin
      pc_m++;
    end
  endtask

  task automatic idle();
    step(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic jump(input logic [ADDR_W-1:0] pc);
    step(1'b0, 1'b1, pc, 1'b0, 1'b0, '0);
  endtask

  task automatic start_load();
    step(1'b0, 1'b0, '0, 1'b1, 1'b0, '0);
  endtask

  task automatic fetch_run(input int n);
    for (int i = 0; i < n; i++) begin
      step(1'b1, 1'b0, '0, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      idle();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout waiting for dec.valid, %0d items never came out", exp_q.size());
      exp_q.delete();
    end
    repeat (3) idle(); // dec.valid must stay low.
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin
    logic [31:0]      r;
    logic [31:0]      w;
    logic [CNT_W-1:0] cnt0;
    int               out0;
    rst = 1'b1;
    run = 1'b0;
    load_start = 1'b0;
    load_valid = 1'b0;
    load_data = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    seed = 32'hd60d7f17;
    errors = 0;
    checks = 0;
    tests = 0;
    n_out = 0;
    test_err0 = 0;
    for (int i = 0; i < IM_WORDS; i++) begin
      mem_m[i] = '0;
    end
    ptr_m = IM_START;
    cnt_m = '0;
    pc_m = IM_START;
    pushed_m = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    out0 = n_out;
    fetch_run(10);
    drain();
    check(n_out - out0, 10, "outputs of the reset run");
    end_test("reset contents");

    start_load();
    for (int i = 0; i < 40; i++) begin
      step(1'b0, 1'b0, '0, 1'b0, 1'b1, rand_word());
    end
    idle();
    check(load_count, 40, "load_count after 40 loads");
    jump(IM_START);
    out0 = n_out;
    fetch_run(40);
    drain();
    check(n_out - out0, 40, "outputs of the load run");
    end_test("load and fetch");

    start_load();
    for (int i = 0; i < 32; i++) begin
      r = rand32();
      w = rand32();
      w[31:26] = iops[r[2:0]];
      w[15] = 1'b1; // negative immediate.
      step(1'b0, 1'b0, '0, 1'b0, 1'b1, w);
    end
    jump(IM_START);
    fetch_run(32);
    drain();
    end_test("immediate extension");

    start_load();
    for (int i = 0; i < 260; i++) begin
      step(1'b0, 1'b0, '0, 1'b0, 1'b1, rand_word());
    end
    idle();
    check(load_count, IM_WORDS, "load_count saturated");
    jump(IM_START);
    for (int i = 0; i < 200; i++) begin
      r = rand32();
      step(1'b1, r[2:0] == 3'd0, r[15:8], 1'b0, 1'b0, '0);
    end
    drain();
    end_test("redirects");

    // count well below saturation so stray loads would show.
    start_load();
    for (int i = 0; i < 8; i++) begin
      step(1'b0, 1'b0, '0, 1'b0, 1'b1, rand_word());
    end
    cnt0 = cnt_m;
    jump(IM_START);
    for (int i = 0; i < 30; i++) begin
      step(1'b1, 1'b0, '0, 1'b0, 1'b1, rand32());
    end
    drain();
    check(load_count, cnt0, "load_count after loads while running");
    step(1'b0, 1'b0, '0, 1'b0, 1'b1, rand_word());
    jump(IM_START);
    fetch_run(64);
    drain();
    end_test("loads while running");

    jump(IM_START + 8'h10);
    fetch_run(12);
    out0 = n_out;
    drain();
    check(n_out - out0, 2, "items out after run drops");
    end_test("drain");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/fetch_pkg.sv
rtl/instr_mem.sv
rtl/im_loader.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
rtl/fetch_top.sv
dv/fetch_props.sv
dv/fetch_top_tb.sv
